// File: hw/color_shader.sv
// RGB shading of a hit voxel: light, emission, floor shadow, selection highlight
`timescale 1ns/1ps

module color_shader (
    input  logic                                  clk,
    input  logic                                  rst_n,
    ray_hit_if.sink                               hit_bus,
    input  logic                                  sel_active,
    input  logic [voxel_render_pkg::coord_width-1:0] sel_x,
    input  logic [voxel_render_pkg::coord_width-1:0] sel_y,
    input  logic [voxel_render_pkg::coord_width-1:0] sel_z,
    output logic                                  shade_valid,
    output logic [23:0]                           rgb
);
    import voxel_render_pkg::*;

    // Channel 2 is red, channel 0 is blue
    logic [2:0][7:0] colour;
    logic [2:0][7:0] lit;
    logic [2:0][7:0] glow;
    logic [2:0][7:0] floor_c;
    logic [2:0][7:0] shade_c;
    logic [7:0]      light;
    logic [7:0]      emissive;
    logic signed [6:0] dx;
    logic signed [6:0] dz;
    logic [11:0]     dist2;
    logic            in_floor;
    logic            shadowed;
    logic            selected;

    function automatic logic [7:0] sat_add(input logic [7:0] a, input logic [7:0] b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    // c * s >> 8
    function automatic logic [7:0] scale(input logic [7:0] c, input logic [7:0] s);
        logic [15:0] prod;
        prod = c * s;
        return prod[15:8];
    endfunction

    assign colour   = hit_bus.voxel.fields.colour;
    assign light    = hit_bus.voxel.fields.light;
    assign emissive = hit_bus.voxel.fields.emissive;

    // ----------------------------------------
    // Floor shadow disc and selection match
    // ----------------------------------------
    assign dx       = $signed({1'b0, hit_bus.vx}) - 7'(shadow_cx);
    assign dz       = $signed({1'b0, hit_bus.vz}) - 7'(shadow_cz);
    assign dist2    = dx * dx + dz * dz;
    assign in_floor = (int'(hit_bus.vy) >= floor_min_y) && (int'(hit_bus.vy) <= floor_max_y);
    assign shadowed = (int'(dist2) <= shadow_radius2);
    assign selected = sel_active && ({hit_bus.vx, hit_bus.vy, hit_bus.vz} == {sel_x, sel_y, sel_z});

    always_comb begin
        for (int i = 0; i < 3; i++)
            lit[i] = scale(colour[i], light);
        // Keep the voxel visible when light or colour zeroes everything
        if (lit == '0)
            lit = colour;

        for (int i = 0; i < 3; i++)
            glow[i] = (emissive != 8'd0) ? sat_add(lit[i], scale(lit[i], emissive)) : lit[i];

        for (int i = 0; i < 3; i++) begin
            floor_c[i] = glow[i];
            if (in_floor && shadowed)
                floor_c[i] = scale(glow[i], shadow_scale_dark);
            else if (in_floor)
                floor_c[i] = sat_add(scale(glow[i], shadow_scale_lit), bounce_rgb[i]);
        end

        for (int i = 0; i < 3; i++)
            shade_c[i] = selected ? sat_add(floor_c[i], select_rgb[i]) : floor_c[i];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            shade_valid <= 1'b0;
        else
            shade_valid <= hit_bus.ray_done;
    end

    always_ff @(posedge clk) begin
        if (hit_bus.ray_done)
            rgb <= shade_c;
    end

endmodule

// File: hw/material_shader.sv
// Material ID and the reflection/refraction/attenuation/emission word
`timescale 1ns/1ps

module material_shader (
    input  logic        clk,
    input  logic        rst_n,
    ray_hit_if.sink     hit_bus,
    output logic [31:0] material_word,
    output logic [7:0]  material_id
);

    logic [3:0] mtype;
    logic [7:0] reflection;
    logic [7:0] refraction;
    logic [7:0] emission;

    assign mtype = hit_bus.voxel.fields.material_type;

    // Types 3 and 5 are mirrors, 2 and 5 refract, 1 emits
    always_comb begin
        case (mtype)
            4'd3:    reflection = 8'd255;
            4'd5:    reflection = 8'd200;
            default: reflection = {hit_bus.voxel.fields.props[7:5], 5'd0};
        endcase
        case (mtype)
            4'd5:    refraction = 8'd128;
            4'd2:    refraction = 8'd85;
            default: refraction = 8'd0;
        endcase
        emission = (mtype == 4'd1) ? hit_bus.voxel.fields.emissive : 8'd0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            material_word <= '0;
            material_id   <= '0;
        end else if (hit_bus.ray_done) begin
            material_word <= {reflection, refraction, hit_bus.ray_steps, emission};
            material_id   <= {mtype, 4'h0};
        end
    end

endmodule

// File: hw/pixel_writer.sv
// Framebuffer write stage: hit or sky selection, word packing, address and done
`timescale 1ns/1ps

module pixel_writer (
    input  logic                                       clk,
    input  logic                                       rst_n,
    ray_hit_if.sink                                    hit_bus,
    input  logic                                       shade_valid,
    input  logic [23:0]                                rgb,
    input  logic [31:0]                                material_word,
    input  logic [7:0]                                 material_id,
    output logic [31:0]                                pixel_word0,
    output logic [31:0]                                pixel_word1,
    output logic [31:0]                                pixel_word2,
    output logic [voxel_render_pkg::pixel_addr_width-1:0] pixel_addr,
    output logic                                       pixel_write_en,
    output logic                                       done
);
    import voxel_render_pkg::*;

    logic                     hit_q;
    logic                     last_q;
    logic [pixel_x_width-1:0] px_q;
    logic [pixel_y_width-1:0] py_q;
    logic [7:0]               sky_r;
    logic [7:0]               sky_g;
    logic [7:0]               sky_b;

    // Held for the shader cycle
    always_ff @(posedge clk) begin
        if (hit_bus.ray_done) begin
            hit_q  <= hit_bus.hit;
            last_q <= hit_bus.frame_last;
            px_q   <= hit_bus.pixel_x;
            py_q   <= hit_bus.pixel_y;
        end
    end

    // Sky gets brighter toward the bottom rows
    assign sky_r = 8'd10 + 8'(py_q >> 3);
    assign sky_g = 8'd40 + 8'(py_q >> 3);
    assign sky_b = 8'd90 + 8'(py_q >> 2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_write_en <= 1'b0;
            done           <= 1'b0;
        end else begin
            pixel_write_en <= shade_valid;
            done           <= shade_valid && last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (shade_valid) begin
            pixel_word0 <= hit_q ? material_word : sky_word0;
            pixel_word1 <= hit_q ? {rgb, material_id} : {sky_r, sky_g, sky_b, sky_material_id};
            pixel_addr  <= pixel_addr_width'(py_q) * pixel_addr_width'(screen_width)
                         + pixel_addr_width'(px_q);
        end
    end

    assign pixel_word2 = normal_word;

endmodule

// File: hw/ray_hit_if.sv
// Result of one finished ray, marcher to shaders and pixel writer
`timescale 1ns/1ps

interface ray_hit_if;
    import voxel_render_pkg::*;

    // Every field is valid only while ray_done is high
    logic                     ray_done;
    logic                     hit;
    voxel_word_u              voxel;
    logic [coord_width-1:0]   vx;
    logic [coord_width-1:0]   vy;
    logic [coord_width-1:0]   vz;
    logic [7:0]               ray_steps;
    logic [pixel_x_width-1:0] pixel_x;
    logic [pixel_y_width-1:0] pixel_y;
    logic                     frame_last;

    modport marcher (
        output ray_done, hit, voxel, vx, vy, vz, ray_steps, pixel_x, pixel_y, frame_last
    );

    modport sink (
        input ray_done, hit, voxel, vx, vy, vz, ray_steps, pixel_x, pixel_y, frame_last
    );

endinterface

// File: hw/ray_marcher.sv
// Raster scan, orthographic ray setup, -X half-voxel stepping and first-hit detection
`timescale 1ns/1ps

module ray_marcher (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    output logic [3*voxel_render_pkg::coord_width-1:0] voxel_addr,
    output logic                                   voxel_read_en,
    input  logic [63:0]                            voxel_data,
    output logic                                   busy,
    ray_hit_if.marcher                             hit_bus
);
    import voxel_render_pkg::*;

    logic [2:0]               state;
    logic [pixel_x_width-1:0] px;
    logic [pixel_y_width-1:0] py;
    logic [7:0]               steps;
    logic                     hit;
    logic                     ray_done;

    // Ray datapath
    logic [pos_width-1:0]     pos_x;
    logic [coord_width-1:0]   map_y;
    logic [coord_width-1:0]   map_z;
    logic [coord_width-1:0]   cur_x;
    logic [coord_width-1:0]   sample_x;
    logic [coord_width-1:0]   setup_y;
    logic [coord_width-1:0]   setup_z;
    voxel_word_u              fetched;
    voxel_word_u              hit_voxel;
    logic                     sample_hit;
    logic                     ray_end;
    logic                     last_pixel;

    // Screen row 0 is the top of the volume
    assign setup_y = coord_width'(((screen_height - 1 - int'(py)) * (grid_size - 1))
                                  / (screen_height - 1));
    assign setup_z = coord_width'((int'(px) * (grid_size - 1)) / (screen_width - 1));

    // Sample at the floor of the x position, which wraps when the ray leaves the grid
    assign sample_x   = pos_x[frac_bits +: coord_width];
    assign fetched    = voxel_data;
    assign sample_hit = (fetched.raw != '0) && (fetched.fields.alpha > 8'(alpha_threshold));
    assign ray_end    = hit || (steps == 8'(max_steps));
    assign last_pixel = (px == pixel_x_width'(screen_width - 1))
                     && (py == pixel_y_width'(screen_height - 1));

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            busy          <= 1'b0;
            voxel_read_en <= 1'b0;
            ray_done      <= 1'b0;
            px            <= '0;
            py            <= '0;
            steps         <= '0;
            hit           <= 1'b0;
        end else begin
            voxel_read_en <= 1'b0;
            ray_done      <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        busy  <= 1'b1;
                        px    <= '0;
                        py    <= '0;
                        state <= st_setup;
                    end
                end
                st_setup: begin
                    steps <= '0;
                    hit   <= 1'b0;
                    state <= st_step;
                end
                st_step: begin
                    if (ray_end) begin
                        ray_done <= 1'b1;
                        state    <= st_next;
                    end else begin
                        voxel_read_en <= 1'b1;
                        steps         <= steps + 8'd1;
                        state         <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (sample_hit)
                        hit <= 1'b1;
                    state <= st_step;
                end
                st_next: begin
                    if (last_pixel) begin
                        busy  <= 1'b0;
                        state <= st_idle;
                    end else if (px == pixel_x_width'(screen_width - 1)) begin
                        px    <= '0;
                        py    <= py + 1'b1;
                        state <= st_setup;
                    end else begin
                        px    <= px + 1'b1;
                        state <= st_setup;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Position, address and hit voxel
    always_ff @(posedge clk) begin
        if (state == st_setup) begin
            map_y <= setup_y;
            map_z <= setup_z;
            pos_x <= pos_width'((grid_size - 1) << frac_bits);
        end
        if (state == st_step && !ray_end) begin
            cur_x      <= sample_x;
            voxel_addr <= {sample_x, map_y, map_z};
            pos_x      <= pos_x - pos_width'(1 << (frac_bits - 1));
        end
        if (state == st_fetch && sample_hit)
            hit_voxel <= fetched;
    end

    assign hit_bus.ray_done   = ray_done;
    assign hit_bus.hit        = hit;
    assign hit_bus.voxel      = hit_voxel;
    assign hit_bus.vx         = cur_x;
    assign hit_bus.vy         = map_y;
    assign hit_bus.vz         = map_z;
    assign hit_bus.ray_steps  = steps;
    assign hit_bus.pixel_x    = px;
    assign hit_bus.pixel_y    = py;
    assign hit_bus.frame_last = last_pixel;

endmodule

// File: hw/voxel_raycaster.sv
// Voxel ray caster top level: marcher, colour and material shaders, pixel writer
`timescale 1ns/1ps

module voxel_raycaster (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          start,
    input  logic                                          sel_active,
    input  logic [voxel_render_pkg::coord_width-1:0]      sel_x,
    input  logic [voxel_render_pkg::coord_width-1:0]      sel_y,
    input  logic [voxel_render_pkg::coord_width-1:0]      sel_z,
    output logic [3*voxel_render_pkg::coord_width-1:0]    voxel_addr,
    output logic                                          voxel_read_en,
    input  logic [63:0]                                   voxel_data,
    output logic [31:0]                                   pixel_word0,
    output logic [31:0]                                   pixel_word1,
    output logic [31:0]                                   pixel_word2,
    output logic [voxel_render_pkg::pixel_addr_width-1:0] pixel_addr,
    output logic                                          pixel_write_en,
    output logic                                          busy,
    output logic                                          done
);

    logic        shade_valid;
    logic [23:0] rgb;
    logic [31:0] material_word;
    logic [7:0]  material_id;

    ray_hit_if hit_bus ();

    ray_marcher marcher_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .voxel_addr    (voxel_addr),
        .voxel_read_en (voxel_read_en),
        .voxel_data    (voxel_data),
        .busy          (busy),
        .hit_bus       (hit_bus.marcher)
    );

    color_shader color_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .hit_bus     (hit_bus.sink),
        .sel_active  (sel_active),
        .sel_x       (sel_x),
        .sel_y       (sel_y),
        .sel_z       (sel_z),
        .shade_valid (shade_valid),
        .rgb         (rgb)
    );

    material_shader material_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .hit_bus       (hit_bus.sink),
        .material_word (material_word),
        .material_id   (material_id)
    );

    pixel_writer writer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .hit_bus        (hit_bus.sink),
        .shade_valid    (shade_valid),
        .rgb            (rgb),
        .material_word  (material_word),
        .material_id    (material_id),
        .pixel_word0    (pixel_word0),
        .pixel_word1    (pixel_word1),
        .pixel_word2    (pixel_word2),
        .pixel_addr     (pixel_addr),
        .pixel_write_en (pixel_write_en),
        .done           (done)
    );

endmodule

// File: hw/voxel_render_pkg.sv
// Shared geometry, march FSM codes, shading constants and the voxel word layout
package voxel_render_pkg;

    // ----------------------------------------
    // Screen and volume geometry
    // ----------------------------------------
    localparam int screen_width     = 32;
    localparam int screen_height    = 24;
    localparam int pixel_x_width    = 5;
    localparam int pixel_y_width    = 5;
    localparam int grid_size        = 64;
    localparam int coord_width      = 6;
    localparam int frac_bits        = 8;
    // Ray x position with one spare bit so the last sample can go below zero
    localparam int pos_width        = coord_width + frac_bits + 1;
    localparam int max_steps        = 128;
    localparam int alpha_threshold  = 10;
    localparam int pixel_addr_width = 32;

    // March FSM encoding
    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_setup = 3'd1;
    localparam logic [2:0] st_step  = 3'd2;
    localparam logic [2:0] st_fetch = 3'd3;
    localparam logic [2:0] st_next  = 3'd4;

    // ----------------------------------------
    // Floor shadow and colour offsets
    // ----------------------------------------
    localparam int floor_min_y    = 8;
    localparam int floor_max_y    = 16;
    localparam int shadow_cx      = 32;
    localparam int shadow_cz      = 32;
    localparam int shadow_radius2 = 324;

    localparam logic [7:0] shadow_scale_dark = 8'd80;
    localparam logic [7:0] shadow_scale_lit  = 8'd206;

    // Channel order is R, G, B from the top byte down
    localparam logic [2:0][7:0] bounce_rgb = {8'd20, 8'd12, 8'd4};
    localparam logic [2:0][7:0] select_rgb = {8'd96, 8'd16, 8'd96};

    // Sky pixel and the fixed up-vector normal word
    localparam logic [7:0]  sky_material_id = 8'hFF;
    localparam logic [31:0] sky_word0       = {8'd0, 8'd0, 8'd255, 8'd0};
    localparam logic [31:0] normal_word     = {8'd0, 8'd0, 8'd127, 8'd0};

    // ----------------------------------------
    // Voxel word
    // ----------------------------------------
    typedef struct packed {
        logic [7:0]  props;
        logic [7:0]  emissive;
        logic [7:0]  alpha;
        logic [7:0]  light;
        logic [23:0] colour;
        logic [3:0]  material_type;
        logic [3:0]  reserved;
    } voxel_fields_t;

    typedef union packed {
        logic [63:0]   raw;
        voxel_fields_t fields;
    } voxel_word_u;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the voxel ray caster testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module voxel_raycaster_tb \
    -f voxel_raycaster.f -o sim_voxel_raycaster > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_voxel_raycaster > sim.log 2>&1
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1
grep -qF '*** TEST PASSED ***' sim.log || exit 1
echo "Simulation passed"

// File: tb/voxel_raycaster_assertions.sv
// Concurrent protocol checks for the voxel ray caster, bound into the top level
`timescale 1ns/1ps

module voxel_raycaster_assertions (
    input logic                                          clk,
    input logic                                          rst_n,
    input logic                                          busy,
    input logic                                          done,
    input logic                                          pixel_write_en,
    input logic                                          voxel_read_en,
    input logic [voxel_render_pkg::pixel_addr_width-1:0] pixel_addr
);
    import voxel_render_pkg::*;

    // Frame end comes with its own last write
    done_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> pixel_write_en)
        else $error("done pulsed without a pixel write");

    // The memory is only read during a frame
    read_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        voxel_read_en |-> busy)
        else $error("voxel read outside a frame");

    addr_in_screen: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_write_en |-> (pixel_addr < pixel_addr_width'(screen_width * screen_height)))
        else $error("pixel address beyond the screen");

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !busy)
        else $error("busy high right after reset");

endmodule

// File: tb/voxel_raycaster_tb.sv
// Testbench for the voxel ray caster: clock, reset, voxel memory model,
// reference model of march and shading, directed frame tests
`timescale 1ns/1ps

module voxel_raycaster_tb;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        sel_active;
    logic [5:0]  sel_x;
    logic [5:0]  sel_y;
    logic [5:0]  sel_z;
    logic [17:0] voxel_addr;
    logic        voxel_read_en;
    logic [63:0] voxel_data;
    logic [31:0] pixel_word0;
    logic [31:0] pixel_word1;
    logic [31:0] pixel_word2;
    logic [31:0] pixel_addr;
    logic        pixel_write_en;
    logic        busy;
    logic        done;

    // Scene indexed by {x, y, z}
    logic [63:0] scene [0:262143];
    int          seed = 32'h08b0c014;
    bit          fail_reported;
    bit          run_passed;

    voxel_raycaster dut_i (.*);

    bind voxel_raycaster voxel_raycaster_assertions assertions_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .busy           (busy),
        .done           (done),
        .pixel_write_en (pixel_write_en),
        .voxel_read_en  (voxel_read_en),
        .pixel_addr     (pixel_addr)
    );

    // Memory answers only in a read cycle and drives all ones otherwise
    assign voxel_data = voxel_read_en ? scene[voxel_addr] : '1;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        fail_reported = 1'b1;
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input int pixel,
                               input logic [31:0] got, input logic [31:0] expected);
        assert (got === expected)
        else abort_run($sformatf("ERROR %s at pixel %0d: got %h expected %h",
                                 name, pixel, got, expected));
    endtask

    function automatic int clamp8(input int value);
        return (value > 255) ? 255 : value;
    endfunction

    function automatic int voxel_index(input int x, input int y, input int z);
        return x * 4096 + y * 64 + z;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Samples floor(63 - k/2) for k = 0..127 and wraps x to 63 on the last one
    task automatic trace_ray(input int px, input int py, output bit hit,
                             output int vx, output int vy, output int vz,
                             output int steps, output logic [63:0] vox);
        int k;
        int x;
        logic [63:0] sample;
        hit   = 1'b0;
        steps = 128;
        vx    = 0;
        vox   = '0;
        vy    = ((23 - py) * 63) / 23;
        vz    = (px * 63) / 31;
        for (k = 0; k < 128 && !hit; k++) begin
            x      = (63 - (k + 1) / 2) & 63;
            sample = scene[voxel_index(x, vy, vz)];
            if (sample != '0 && sample[47:40] > 8'd10) begin
                hit   = 1'b1;
                steps = k + 1;
                vx    = x;
                vox   = sample;
            end
        end
    endtask

    function automatic logic [23:0] expected_rgb(input logic [63:0] vox, input int vx,
                                                 input int vy, input int vz);
        int  c[3];
        int  lit[3];
        int  bounce[3];
        int  highlight[3];
        int  light;
        int  emis;
        int  i;
        bit  dark;
        bounce    = '{20, 12, 4};
        highlight = '{96, 16, 96};
        light     = int'(vox[39:32]);
        emis      = int'(vox[55:48]);
        for (i = 0; i < 3; i++) begin
            c[i]   = int'(vox[31 - 8 * i -: 8]);
            lit[i] = (c[i] * light) >> 8;
        end
        // Raw colour when light blacks out the voxel
        if (lit[0] + lit[1] + lit[2] != 0)
            c = lit;
        dark = (((vx - 32) * (vx - 32) + (vz - 32) * (vz - 32)) <= 324);
        for (i = 0; i < 3; i++) begin
            if (emis != 0)
                c[i] = clamp8(c[i] + ((emis * c[i]) >> 8));
            if (vy >= 8 && vy <= 16) begin
                c[i] = (c[i] * (dark ? 80 : 206)) >> 8;
                if (!dark)
                    c[i] = clamp8(c[i] + bounce[i]);
            end
            if (sel_active && vx == sel_x && vy == sel_y && vz == sel_z)
                c[i] = clamp8(c[i] + highlight[i]);
        end
        return {8'(c[0]), 8'(c[1]), 8'(c[2])};
    endfunction

    function automatic logic [31:0] expected_material(input logic [63:0] vox, input int steps);
        int mtype;
        int reflection;
        int refraction;
        int emission;
        mtype      = int'(vox[7:4]);
        reflection = (mtype == 3) ? 255 : (mtype == 5) ? 200 : int'(vox[63:61]) * 32;
        refraction = (mtype == 5) ? 128 : (mtype == 2) ? 85 : 0;
        emission   = (mtype == 1) ? int'(vox[55:48]) : 0;
        return {8'(reflection), 8'(refraction), 8'(steps), 8'(emission)};
    endfunction

    // ----------------------------------------
    // Scene setup and frame checking
    // ----------------------------------------
    task automatic clear_scene();
        int i;
        for (i = 0; i < 262144; i++)
            scene[i] = '0;
    endtask

    // Light is zero one time in four and emissive about half the time
    function automatic logic [63:0] random_voxel(input int alpha);
        logic [63:0] vox;
        vox        = {$random(seed), $random(seed)};
        vox[47:40] = 8'(alpha);
        vox[7:4]   = 4'($unsigned($random(seed)) % 6);
        vox[3:0]   = 4'd0;
        if (vox[33:32] == 2'd0)
            vox[39:32] = 8'd0;
        if (vox[50])
            vox[55:48] = 8'd0;
        return vox;
    endfunction

    task automatic run_frame(input bit expect_hits, input bit restart_mid);
        int          writes;
        int          hits;
        int          wait_cycles;
        int          vx;
        int          vy;
        int          vz;
        int          steps;
        bit          hit;
        logic [63:0] vox;
        logic [31:0] exp0;
        logic [31:0] exp1;
        wait_cycles = 0;
        while (busy) begin
            assert (wait_cycles < 400) else abort_run("DUT still busy before a new frame");
            @(negedge clk);
            wait_cycles++;
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (busy) else abort_run("busy did not rise after start");
        writes = 0;
        hits   = 0;
        while (writes < 768) begin
            wait_cycles = 0;
            while (!pixel_write_en) begin
                assert (wait_cycles < 400) else abort_run("no pixel write within 400 cycles");
                @(negedge clk);
                wait_cycles++;
            end
            trace_ray(writes % 32, writes / 32, hit, vx, vy, vz, steps, vox);
            if (hit) begin
                hits++;
                exp0 = expected_material(vox, steps);
                exp1 = {expected_rgb(vox, vx, vy, vz), vox[7:4], 4'h0};
            end else begin
                exp0 = 32'h0000FF00;
                exp1 = {8'(10 + (writes / 32) / 8), 8'(40 + (writes / 32) / 8),
                        8'(90 + (writes / 32) / 4), 8'hFF};
            end
            check_value("pixel_addr", writes, pixel_addr, 32'(writes));
            check_value("pixel_word0", writes, pixel_word0, exp0);
            check_value("pixel_word1", writes, pixel_word1, exp1);
            check_value("pixel_word2", writes, pixel_word2, 32'h00007F00);
            check_value("done", writes, 32'(done), 32'(writes == 767));
            writes++;
            // A second start in the middle of the frame must be ignored
            if (restart_mid && writes == 100) begin
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
        assert (expect_hits ? (hits > 0) : (hits == 0))
        else abort_run("scene does not give the intended mix of hits and sky");
        wait_cycles = 0;
        while (busy) begin
            assert (wait_cycles < 10) else abort_run("busy stayed high after the frame");
            @(negedge clk);
            wait_cycles++;
        end
        repeat (300) begin
            assert (!pixel_write_en && !done) else abort_run("write or done after the frame");
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic empty_volume_frame();
        clear_scene();
        run_frame(1'b0, 1'b0);
    endtask

    task automatic fill_slab(input int x);
        int y;
        int z;
        for (y = 0; y < 64; y++)
            for (z = 0; z < 64; z++)
                scene[voxel_index(x, y, z)] = random_voxel(11 + $unsigned($random(seed)) % 245);
    endtask

    task automatic solid_slab_frame();
        clear_scene();
        fill_slab(40);
        run_frame(1'b1, 1'b0);
    endtask

    // Alpha 10 layer is see-through and the wall behind covers only the lower half
    task automatic translucent_layer_frame();
        int y;
        int z;
        clear_scene();
        for (y = 0; y < 64; y++) begin
            for (z = 0; z < 64; z++) begin
                scene[voxel_index(50, y, z)] = random_voxel(10);
                if (y < 32)
                    scene[voxel_index(30, y, z)] = random_voxel(200);
            end
        end
        run_frame(1'b1, 1'b0);
    endtask

    // Floor band at x = 32 crosses the shadow disc while the wall above it stays unshaded
    task automatic floor_shadow_frame();
        int y;
        int z;
        clear_scene();
        for (z = 0; z < 64; z++) begin
            for (y = 8; y <= 16; y++)
                scene[voxel_index(32, y, z)] = random_voxel(255);
            for (y = 20; y <= 40; y++)
                scene[voxel_index(45, y, z)] = random_voxel(255);
        end
        // Seen by pixel (10, 18)
        sel_active = 1'b1;
        sel_x      = 6'd32;
        sel_y      = 6'd13;
        sel_z      = 6'd20;
        run_frame(1'b1, 1'b0);
        sel_active = 1'b0;
    endtask

    task automatic restart_while_busy();
        clear_scene();
        fill_slab(40);
        run_frame(1'b1, 1'b1);
        run_frame(1'b1, 1'b0);
    endtask

    initial begin
        rst_n         = 1'b0;
        start         = 1'b0;
        sel_active    = 1'b0;
        sel_x         = '0;
        sel_y         = '0;
        sel_z         = '0;
        fail_reported = 1'b0;
        run_passed    = 1'b0;
        clear_scene();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        empty_volume_frame();
        solid_slab_frame();
        translucent_layer_frame();
        floor_shadow_frame();
        restart_while_busy();
        run_passed = 1'b1;
        $display("*** TEST PASSED ***");
        $finish;
    end

    final begin
        if (!run_passed && !fail_reported)
            $display("*** TEST FAILED ***");
    end

endmodule

// File: voxel_raycaster.f
hw/voxel_render_pkg.sv
hw/ray_hit_if.sv
hw/ray_marcher.sv
hw/color_shader.sv
hw/material_shader.sv
hw/pixel_writer.sv
hw/voxel_raycaster.sv
tb/voxel_raycaster_assertions.sv
tb/voxel_raycaster_tb.sv
